/* include/rv_config.svh */
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// datapath, pc and operand width
`define RV_XLEN 32

// register file address, 32 registers
`define RV_REG_AW 5

// rs1 and rs2
`define RV_NUM_SRC 2

`endif

/* hdl/rv_isa_pkg.sv */
package rv_isa_pkg;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011
	} opcode_e;

	// funct3 for OP and OP-IMM
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SRL_SRA = 3'b101;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// branches
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	// loads and stores
	localparam logic [2:0] F3_LB  = 3'b000;
	localparam logic [2:0] F3_LH  = 3'b001;
	localparam logic [2:0] F3_LW  = 3'b010;
	localparam logic [2:0] F3_LBU = 3'b100;
	localparam logic [2:0] F3_LHU = 3'b101;
	localparam logic [2:0] F3_SB  = 3'b000;
	localparam logic [2:0] F3_SH  = 3'b001;
	localparam logic [2:0] F3_SW  = 3'b010;

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000; // sub, sra, srai

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcode_e    opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		opcode_e     opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		opcode_e    opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		opcode_e    opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		opcode_e     opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		opcode_e    opcode;
	} j_fmt_t;

	// one instruction word seen through every format
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} inst_u;

endpackage

/* hdl/rv_pipe_pkg.sv */
package rv_pipe_pkg;

	// operation code handed to execute
	typedef enum logic [7:0] {
		ALU_NOP    = 8'b00000000,
		ALU_AND    = 8'b00100100,
		ALU_OR     = 8'b00100101,
		ALU_XOR    = 8'b00100110,
		ALU_SLL    = 8'b01111100,
		ALU_SRL    = 8'b00000010,
		ALU_SRA    = 8'b00000011,
		ALU_SLT    = 8'b00101010,
		ALU_SLTU   = 8'b00101011,
		ALU_ADD    = 8'b00100000,
		ALU_ADDI   = 8'b01010101,
		ALU_SUB    = 8'b00100010,
		ALU_JAL    = 8'b01010000,
		ALU_JALR   = 8'b00001001,
		ALU_BRANCH = 8'b01010001, // all six conditional branches
		ALU_LB     = 8'b11100000,
		ALU_LH     = 8'b11100001,
		ALU_LW     = 8'b11100011,
		ALU_LBU    = 8'b11100100,
		ALU_LHU    = 8'b11100101,
		ALU_SB     = 8'b11101000,
		ALU_SH     = 8'b11101001,
		ALU_SW     = 8'b11101011
	} aluop_e;

	// which result execute forwards
	typedef enum logic [2:0] {
		SEL_NOP         = 3'b000,
		SEL_LOGIC       = 3'b001,
		SEL_SHIFT       = 3'b010,
		SEL_ARITH       = 3'b100,
		SEL_JUMP_BRANCH = 3'b110,
		SEL_LOAD_STORE  = 3'b111
	} alusel_e;

	// nine kinds do not fit in three bits
	typedef enum logic [3:0] {
		BR_NONE, BR_JAL, BR_JALR, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
	} br_cond_e;

endpackage

/* hdl/id_if.sv */
`include "rv_config.svh"

// one source operand, decoder to mux to branch logic
interface src_if;
	logic                  read_en;
	logic [`RV_REG_AW-1:0] addr;
	logic [`RV_XLEN-1:0]   imm;  // taken when read_en is low
	logic [`RV_XLEN-1:0]   data; // resolved operand

	modport decoder (output read_en, output addr, output imm);
	modport mux (input read_en, input addr, input imm, output data);
	modport consumer (input data);
endinterface

// writes still in flight in execute and memory
interface bypass_if;
	logic                  ex_wreg;
	logic [`RV_REG_AW-1:0] ex_wd;
	logic [`RV_XLEN-1:0]   ex_wdata;
	logic                  mem_wreg;
	logic [`RV_REG_AW-1:0] mem_wd;
	logic [`RV_XLEN-1:0]   mem_wdata;

	modport sink (
		input ex_wreg,
		input ex_wd,
		input ex_wdata,
		input mem_wreg,
		input mem_wd,
		input mem_wdata
	);
endinterface

/* hdl/inst_decoder.sv */
`include "rv_config.svh"

module inst_decoder (
	input  logic [31:0]              inst_i,
	input  logic [`RV_XLEN-1:0]      pc_i,
	src_if.decoder                   src [`RV_NUM_SRC],
	output rv_pipe_pkg::aluop_e      aluop_o,
	output rv_pipe_pkg::alusel_e     alusel_o,
	output logic [`RV_REG_AW-1:0]    wd_o,
	output logic                     wreg_o,
	output rv_pipe_pkg::br_cond_e    br_cond_o,
	output logic [`RV_XLEN-1:0]      br_offset_o,
	output logic [`RV_XLEN-1:0]      pc_o
);
	localparam logic [`RV_NUM_SRC-1:0] RD_RS1  = `RV_NUM_SRC'(1);
	localparam logic [`RV_NUM_SRC-1:0] RD_BOTH = '1;

	rv_isa_pkg::inst_u      inst;
	logic [`RV_NUM_SRC-1:0] rd_en;
	logic [`RV_XLEN-1:0]    imm;
	logic [`RV_XLEN-1:0]    imm_i;
	logic [`RV_XLEN-1:0]    imm_b;
	logic [`RV_XLEN-1:0]    imm_j;

	// fetch delivers the word byte swapped
	assign inst = {inst_i[7:0], inst_i[15:8], inst_i[23:16], inst_i[31:24]};

	assign imm_i = {{(`RV_XLEN-12){inst.i.imm[11]}}, inst.i.imm};
	assign imm_b = {{(`RV_XLEN-12){inst.b.imm12}}, inst.b.imm11, inst.b.imm10_5,
		inst.b.imm4_1, 1'b0};
	assign imm_j = {{(`RV_XLEN-20){inst.j.imm20}}, inst.j.imm19_12, inst.j.imm11,
		inst.j.imm10_1, 1'b0};

	// OP and OP-IMM share the funct3 map, nop means no match
	function automatic void alu_dec(
		input  logic [2:0]           f3,
		input  logic [6:0]           f7,
		input  logic                 is_imm,
		output rv_pipe_pkg::aluop_e  op,
		output rv_pipe_pkg::alusel_e sel
	);
		op = rv_pipe_pkg::ALU_NOP;
		case (f3)
			rv_isa_pkg::F3_ADD_SUB: begin
				if (is_imm)
					op = rv_pipe_pkg::ALU_ADDI;
				else if (f7 == rv_isa_pkg::F7_BASE)
					op = rv_pipe_pkg::ALU_ADD;
				else if (f7 == rv_isa_pkg::F7_ALT)
					op = rv_pipe_pkg::ALU_SUB;
			end
			rv_isa_pkg::F3_SLL:  op = rv_pipe_pkg::ALU_SLL;
			rv_isa_pkg::F3_SLT:  op = rv_pipe_pkg::ALU_SLT;
			rv_isa_pkg::F3_SLTU: op = rv_pipe_pkg::ALU_SLTU;
			rv_isa_pkg::F3_XOR:  op = rv_pipe_pkg::ALU_XOR;
			rv_isa_pkg::F3_SRL_SRA: begin
				if (f7 == rv_isa_pkg::F7_BASE)
					op = rv_pipe_pkg::ALU_SRL;
				else if (f7 == rv_isa_pkg::F7_ALT)
					op = rv_pipe_pkg::ALU_SRA;
			end
			rv_isa_pkg::F3_OR:   op = rv_pipe_pkg::ALU_OR;
			rv_isa_pkg::F3_AND:  op = rv_pipe_pkg::ALU_AND;
			default: ;
		endcase
		case (op)
			rv_pipe_pkg::ALU_SLL, rv_pipe_pkg::ALU_SRL, rv_pipe_pkg::ALU_SRA:
				sel = rv_pipe_pkg::SEL_SHIFT;
			rv_pipe_pkg::ALU_AND, rv_pipe_pkg::ALU_OR, rv_pipe_pkg::ALU_XOR:
				sel = rv_pipe_pkg::SEL_LOGIC;
			rv_pipe_pkg::ALU_NOP:
				sel = rv_pipe_pkg::SEL_NOP;
			default:
				sel = rv_pipe_pkg::SEL_ARITH;
		endcase
	endfunction

	always_comb begin
		aluop_o = rv_pipe_pkg::ALU_NOP;
		alusel_o = rv_pipe_pkg::SEL_NOP;
		wreg_o = 1'b0;
		rd_en = '0;
		imm = '0;
		br_cond_o = rv_pipe_pkg::BR_NONE;
		br_offset_o = '0;
		case (inst.r.opcode)
			rv_isa_pkg::OPC_LUI: begin
				aluop_o = rv_pipe_pkg::ALU_OR; // zero or imm
				alusel_o = rv_pipe_pkg::SEL_LOGIC;
				wreg_o = 1'b1;
				imm = {inst.u.imm, 12'h000};
			end
			rv_isa_pkg::OPC_JAL: begin
				aluop_o = rv_pipe_pkg::ALU_JAL;
				alusel_o = rv_pipe_pkg::SEL_JUMP_BRANCH;
				wreg_o = 1'b1;
				br_cond_o = rv_pipe_pkg::BR_JAL;
				br_offset_o = imm_j;
			end
			rv_isa_pkg::OPC_JALR: begin
				aluop_o = rv_pipe_pkg::ALU_JALR;
				alusel_o = rv_pipe_pkg::SEL_JUMP_BRANCH;
				wreg_o = 1'b1;
				rd_en = RD_RS1;
				br_cond_o = rv_pipe_pkg::BR_JALR;
				br_offset_o = {{(`RV_XLEN-12){1'b0}}, inst.i.imm}; // zero extended
			end
			rv_isa_pkg::OPC_BRANCH: begin
				case (inst.b.funct3)
					rv_isa_pkg::F3_BEQ:  br_cond_o = rv_pipe_pkg::BR_EQ;
					rv_isa_pkg::F3_BNE:  br_cond_o = rv_pipe_pkg::BR_NE;
					rv_isa_pkg::F3_BLT:  br_cond_o = rv_pipe_pkg::BR_LT;
					rv_isa_pkg::F3_BGE:  br_cond_o = rv_pipe_pkg::BR_GE;
					rv_isa_pkg::F3_BLTU: br_cond_o = rv_pipe_pkg::BR_LTU;
					rv_isa_pkg::F3_BGEU: br_cond_o = rv_pipe_pkg::BR_GEU;
					default: ;
				endcase
				if (br_cond_o != rv_pipe_pkg::BR_NONE) begin
					aluop_o = rv_pipe_pkg::ALU_BRANCH;
					alusel_o = rv_pipe_pkg::SEL_JUMP_BRANCH;
					rd_en = RD_BOTH;
					br_offset_o = imm_b;
				end
			end
			rv_isa_pkg::OPC_LOAD: begin
				case (inst.i.funct3)
					rv_isa_pkg::F3_LB:  aluop_o = rv_pipe_pkg::ALU_LB;
					rv_isa_pkg::F3_LH:  aluop_o = rv_pipe_pkg::ALU_LH;
					rv_isa_pkg::F3_LW:  aluop_o = rv_pipe_pkg::ALU_LW;
					rv_isa_pkg::F3_LBU: aluop_o = rv_pipe_pkg::ALU_LBU;
					rv_isa_pkg::F3_LHU: aluop_o = rv_pipe_pkg::ALU_LHU;
					default: ;
				endcase
				if (aluop_o != rv_pipe_pkg::ALU_NOP) begin
					alusel_o = rv_pipe_pkg::SEL_LOAD_STORE;
					wreg_o = 1'b1;
					rd_en = RD_RS1;
				end
			end
			rv_isa_pkg::OPC_STORE: begin
				case (inst.s.funct3)
					rv_isa_pkg::F3_SB: aluop_o = rv_pipe_pkg::ALU_SB;
					rv_isa_pkg::F3_SH: aluop_o = rv_pipe_pkg::ALU_SH;
					rv_isa_pkg::F3_SW: aluop_o = rv_pipe_pkg::ALU_SW;
					default: ;
				endcase
				if (aluop_o != rv_pipe_pkg::ALU_NOP) begin
					alusel_o = rv_pipe_pkg::SEL_LOAD_STORE;
					rd_en = RD_BOTH; // base and store data
				end
			end
			rv_isa_pkg::OPC_OP_IMM: begin
				alu_dec(inst.i.funct3, inst.r.funct7, 1'b1, aluop_o, alusel_o);
				if (aluop_o != rv_pipe_pkg::ALU_NOP) begin
					wreg_o = 1'b1;
					rd_en = RD_RS1;
					// shifts only take shamt
					imm = (alusel_o == rv_pipe_pkg::SEL_SHIFT) ?
						{{(`RV_XLEN-5){1'b0}}, inst.r.rs2} : imm_i;
				end
			end
			rv_isa_pkg::OPC_OP: begin
				alu_dec(inst.r.funct3, inst.r.funct7, 1'b0, aluop_o, alusel_o);
				if (aluop_o != rv_pipe_pkg::ALU_NOP) begin
					wreg_o = 1'b1;
					rd_en = RD_BOTH;
				end
			end
			default: ;
		endcase
	end

	assign wd_o = inst.r.rd; // follows rd even when disabled
	assign pc_o = pc_i;

	assign src[0].addr = inst.r.rs1;
	assign src[1].addr = inst.r.rs2;

	for (genvar g = 0; g < `RV_NUM_SRC; g++) begin : g_src
		assign src[g].read_en = rd_en[g];
		assign src[g].imm = imm;
	end

endmodule

/* hdl/operand_mux.sv */
`include "rv_config.svh"

module operand_mux (
	src_if.mux                 src,
	bypass_if.sink             byp,
	input logic [`RV_XLEN-1:0] reg_data_i
);

	// youngest write wins, execute before memory before regfile
	always_comb begin
		if (!src.read_en) begin
			src.data = src.imm;
		end else if (byp.ex_wreg && (byp.ex_wd == src.addr)) begin
			src.data = byp.ex_wdata;
		end else if (byp.mem_wreg && (byp.mem_wd == src.addr)) begin
			src.data = byp.mem_wdata;
		end else begin
			src.data = reg_data_i;
		end
		// an unknown address would pick a bypass or regfile word at random
		assert (!src.read_en || !$isunknown(src.addr))
			else $error("operand read with unknown register address");
	end

endmodule

/* hdl/branch_resolve.sv */
`include "rv_config.svh"

module branch_resolve (
	input  logic                         clk_i,
	input  logic                         arst_n_i,
	input  logic                         inst_req_i,
	output logic                         inst_ack_o,
	src_if.consumer                      src [`RV_NUM_SRC],
	input  rv_pipe_pkg::aluop_e          aluop_i,
	input  rv_pipe_pkg::alusel_e         alusel_i,
	input  logic [`RV_REG_AW-1:0]        wd_i,
	input  logic                         wreg_i,
	input  rv_pipe_pkg::br_cond_e        br_cond_i,
	input  logic [`RV_XLEN-1:0]          br_offset_i,
	input  logic [`RV_XLEN-1:0]          pc_i,
	output rv_pipe_pkg::aluop_e          aluop_o,
	output rv_pipe_pkg::alusel_e         alusel_o,
	output logic [`RV_REG_AW-1:0]        wd_o,
	output logic                         wreg_o,
	output logic [`RV_XLEN-1:0]          op1_o,
	output logic [`RV_XLEN-1:0]          op2_o,
	output logic                         branch_flag_o,
	output logic [`RV_XLEN-1:0]          branch_target_o,
	output logic [`RV_XLEN-1:0]          link_addr_o
);
	logic [`RV_XLEN-1:0] op1;
	logic [`RV_XLEN-1:0] op2;
	logic [`RV_XLEN-1:0] target;
	logic                taken;
	logic                capture;

	assign op1 = src[0].data;
	assign op2 = src[1].data;
	assign capture = inst_req_i && !inst_ack_o; // first edge of a new request

	always_comb begin
		case (br_cond_i)
			rv_pipe_pkg::BR_JAL, rv_pipe_pkg::BR_JALR: taken = 1'b1;
			rv_pipe_pkg::BR_EQ:  taken = (op1 == op2);
			rv_pipe_pkg::BR_NE:  taken = (op1 != op2);
			rv_pipe_pkg::BR_LT:  taken = ($signed(op1) < $signed(op2));
			rv_pipe_pkg::BR_GE:  taken = ($signed(op1) >= $signed(op2));
			rv_pipe_pkg::BR_LTU: taken = (op1 < op2);
			rv_pipe_pkg::BR_GEU: taken = (op1 >= op2);
			default:             taken = 1'b0;
		endcase
	end

	// jalr is register relative, the rest pc relative
	assign target = ((br_cond_i == rv_pipe_pkg::BR_JALR) ? op1 : pc_i) + br_offset_i;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			inst_ack_o <= 1'b0;
			aluop_o <= rv_pipe_pkg::ALU_NOP;
			alusel_o <= rv_pipe_pkg::SEL_NOP;
			wreg_o <= 1'b0;
			branch_flag_o <= 1'b0;
		end else if (capture) begin
			inst_ack_o <= 1'b1;
			aluop_o <= aluop_i;
			alusel_o <= alusel_i;
			wreg_o <= wreg_i;
			branch_flag_o <= taken;
		end else if (!inst_req_i) begin
			inst_ack_o <= 1'b0; // return to zero
		end
	end

	always_ff @(posedge clk_i) begin
		if (capture) begin
			wd_o <= wd_i;
			op1_o <= op1;
			op2_o <= op2;
			branch_target_o <= target; // only meaningful with the flag set
			link_addr_o <= pc_i + `RV_XLEN'd4;
		end
	end

	// ack only answers a request that was up on the previous edge
	assert property (@(posedge clk_i) disable iff (!arst_n_i)
		$rose(inst_ack_o) |-> $past(inst_req_i))
		else $error("ack rose without a request");

	// result holds for the whole ack phase
	assert property (@(posedge clk_i) disable iff (!arst_n_i)
		inst_ack_o |=> $stable({aluop_o, alusel_o, wd_o, wreg_o, op1_o, op2_o,
			branch_flag_o, branch_target_o, link_addr_o}))
		else $error("outputs changed while ack high");

endmodule

/* hdl/id_stage.sv */
`include "rv_config.svh"

module id_stage (
	input  logic                         clk_i,
	input  logic                         arst_n_i,
	input  logic                         inst_req_i,
	output logic                         inst_ack_o,
	input  logic [31:0]                  inst_i,
	input  logic [`RV_XLEN-1:0]          pc_i,
	output logic                         reg_read_o [`RV_NUM_SRC],
	output logic [`RV_REG_AW-1:0]        reg_addr_o [`RV_NUM_SRC],
	input  logic [`RV_XLEN-1:0]          reg_data_i [`RV_NUM_SRC],
	input  logic                         ex_wreg_i,
	input  logic [`RV_REG_AW-1:0]        ex_wd_i,
	input  logic [`RV_XLEN-1:0]          ex_wdata_i,
	input  logic                         mem_wreg_i,
	input  logic [`RV_REG_AW-1:0]        mem_wd_i,
	input  logic [`RV_XLEN-1:0]          mem_wdata_i,
	output rv_pipe_pkg::aluop_e          aluop_o,
	output rv_pipe_pkg::alusel_e         alusel_o,
	output logic [`RV_REG_AW-1:0]        wd_o,
	output logic                         wreg_o,
	output logic [`RV_XLEN-1:0]          op1_o,
	output logic [`RV_XLEN-1:0]          op2_o,
	output logic                         branch_flag_o,
	output logic [`RV_XLEN-1:0]          branch_target_o,
	output logic [`RV_XLEN-1:0]          link_addr_o
);
	rv_pipe_pkg::aluop_e   dec_aluop;
	rv_pipe_pkg::alusel_e  dec_alusel;
	logic [`RV_REG_AW-1:0] dec_wd;
	logic                  dec_wreg;
	rv_pipe_pkg::br_cond_e dec_br_cond;
	logic [`RV_XLEN-1:0]   dec_br_offset;
	logic [`RV_XLEN-1:0]   dec_pc;

	src_if    src [`RV_NUM_SRC] ();
	bypass_if byp ();

	assign byp.ex_wreg = ex_wreg_i;
	assign byp.ex_wd = ex_wd_i;
	assign byp.ex_wdata = ex_wdata_i;
	assign byp.mem_wreg = mem_wreg_i;
	assign byp.mem_wd = mem_wd_i;
	assign byp.mem_wdata = mem_wdata_i;

	inst_decoder u_decoder (
		.inst_i      (inst_i),
		.pc_i        (pc_i),
		.src         (src),
		.aluop_o     (dec_aluop),
		.alusel_o    (dec_alusel),
		.wd_o        (dec_wd),
		.wreg_o      (dec_wreg),
		.br_cond_o   (dec_br_cond),
		.br_offset_o (dec_br_offset),
		.pc_o        (dec_pc)
	);

	// one bypass mux per source register
	for (genvar g = 0; g < `RV_NUM_SRC; g++) begin : g_opmux
		assign reg_read_o[g] = src[g].read_en;
		assign reg_addr_o[g] = src[g].addr;

		operand_mux u_mux (
			.src        (src[g]),
			.byp        (byp),
			.reg_data_i (reg_data_i[g])
		);
	end

	branch_resolve u_branch (
		.clk_i           (clk_i),
		.arst_n_i        (arst_n_i),
		.inst_req_i      (inst_req_i),
		.inst_ack_o      (inst_ack_o),
		.src             (src),
		.aluop_i         (dec_aluop),
		.alusel_i        (dec_alusel),
		.wd_i            (dec_wd),
		.wreg_i          (dec_wreg),
		.br_cond_i       (dec_br_cond),
		.br_offset_i     (dec_br_offset),
		.pc_i            (dec_pc),
		.aluop_o         (aluop_o),
		.alusel_o        (alusel_o),
		.wd_o            (wd_o),
		.wreg_o          (wreg_o),
		.op1_o           (op1_o),
		.op2_o           (op2_o),
		.branch_flag_o   (branch_flag_o),
		.branch_target_o (branch_target_o),
		.link_addr_o     (link_addr_o)
	);

endmodule

/* include/id_model.svh */
`ifndef ID_MODEL_SVH
`define ID_MODEL_SVH

// writes in flight in execute and memory
typedef struct packed {
	logic                  ex_wreg;
	logic [`RV_REG_AW-1:0] ex_wd;
	logic [`RV_XLEN-1:0]   ex_wdata;
	logic                  mem_wreg;
	logic [`RV_REG_AW-1:0] mem_wd;
	logic [`RV_XLEN-1:0]   mem_wdata;
} byp_t;

// what the stage should present once ack is up
typedef struct packed {
	logic [7:0]            aluop;
	logic [2:0]            alusel;
	logic [`RV_REG_AW-1:0] wd;
	logic                  wreg;
	logic [`RV_XLEN-1:0]   op1;
	logic [`RV_XLEN-1:0]   op2;
	logic                  flag;
	logic [`RV_XLEN-1:0]   target;
	logic [`RV_XLEN-1:0]   link;
	logic                  rd1; // register file read enables
	logic                  rd2;
} expect_t;

// execute first, then memory, then the register file
function automatic logic [`RV_XLEN-1:0] pick_operand(input logic rd,
	input logic [`RV_REG_AW-1:0] a, input logic [`RV_XLEN-1:0] imm,
	input logic [`RV_XLEN-1:0] rf, input byp_t b);
	if (!rd)
		return imm;
	if (b.ex_wreg && b.ex_wd == a)
		return b.ex_wdata;
	if (b.mem_wreg && b.mem_wd == a)
		return b.mem_wdata;
	return rf;
endfunction

// OP and OP-IMM operation classes
function automatic expect_t alu_expect(input expect_t e, input logic [2:0] f3,
	input logic alt, input logic is_imm);
	case (f3)
		rv_isa_pkg::F3_ADD_SUB: begin
			e.alusel = rv_pipe_pkg::SEL_ARITH;
			if (is_imm)
				e.aluop = rv_pipe_pkg::ALU_ADDI;
			else
				e.aluop = alt ? rv_pipe_pkg::ALU_SUB : rv_pipe_pkg::ALU_ADD;
		end
		rv_isa_pkg::F3_SLL: begin
			e.aluop = rv_pipe_pkg::ALU_SLL;
			e.alusel = rv_pipe_pkg::SEL_SHIFT;
		end
		rv_isa_pkg::F3_SLT: begin
			e.aluop = rv_pipe_pkg::ALU_SLT;
			e.alusel = rv_pipe_pkg::SEL_ARITH;
		end
		rv_isa_pkg::F3_SLTU: begin
			e.aluop = rv_pipe_pkg::ALU_SLTU;
			e.alusel = rv_pipe_pkg::SEL_ARITH;
		end
		rv_isa_pkg::F3_XOR: begin
			e.aluop = rv_pipe_pkg::ALU_XOR;
			e.alusel = rv_pipe_pkg::SEL_LOGIC;
		end
		rv_isa_pkg::F3_SRL_SRA: begin
			e.aluop = alt ? rv_pipe_pkg::ALU_SRA : rv_pipe_pkg::ALU_SRL;
			e.alusel = rv_pipe_pkg::SEL_SHIFT;
		end
		rv_isa_pkg::F3_OR: begin
			e.aluop = rv_pipe_pkg::ALU_OR;
			e.alusel = rv_pipe_pkg::SEL_LOGIC;
		end
		default: begin
			e.aluop = rv_pipe_pkg::ALU_AND;
			e.alusel = rv_pipe_pkg::SEL_LOGIC;
		end
	endcase
	return e;
endfunction

// w in normal bit order, rf1 and rf2 are the regfile words at rs1 and rs2
function automatic expect_t predict(input logic [31:0] w, input logic [`RV_XLEN-1:0] pc_v,
	input byp_t b, input logic [`RV_XLEN-1:0] rf1, input logic [`RV_XLEN-1:0] rf2);
	expect_t e;
	logic rd1;
	logic rd2;
	logic [`RV_XLEN-1:0] imm;
	logic [`RV_XLEN-1:0] off;
	e = '0;
	rd1 = 1'b0;
	rd2 = 1'b0;
	imm = '0;
	off = '0;
	e.wd = w[11:7]; // rd field, whatever the format
	e.link = pc_v + 32'd4;
	case (w[6:0])
		rv_isa_pkg::OPC_LUI: begin
			e.aluop = rv_pipe_pkg::ALU_OR;
			e.alusel = rv_pipe_pkg::SEL_LOGIC;
			e.wreg = 1'b1;
			imm = {w[31:12], 12'h000};
		end
		rv_isa_pkg::OPC_JAL: begin
			e.aluop = rv_pipe_pkg::ALU_JAL;
			e.alusel = rv_pipe_pkg::SEL_JUMP_BRANCH;
			e.wreg = 1'b1;
			off = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
		end
		rv_isa_pkg::OPC_JALR: begin
			e.aluop = rv_pipe_pkg::ALU_JALR;
			e.alusel = rv_pipe_pkg::SEL_JUMP_BRANCH;
			e.wreg = 1'b1;
			rd1 = 1'b1;
			off = {20'h00000, w[31:20]}; // not sign extended
		end
		rv_isa_pkg::OPC_BRANCH: begin
			e.aluop = rv_pipe_pkg::ALU_BRANCH;
			e.alusel = rv_pipe_pkg::SEL_JUMP_BRANCH;
			rd1 = 1'b1;
			rd2 = 1'b1;
			off = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
		end
		rv_isa_pkg::OPC_LOAD: begin
			e.alusel = rv_pipe_pkg::SEL_LOAD_STORE;
			e.wreg = 1'b1;
			rd1 = 1'b1;
			case (w[14:12])
				rv_isa_pkg::F3_LB: e.aluop = rv_pipe_pkg::ALU_LB;
				rv_isa_pkg::F3_LH: e.aluop = rv_pipe_pkg::ALU_LH;
				rv_isa_pkg::F3_LW: e.aluop = rv_pipe_pkg::ALU_LW;
				rv_isa_pkg::F3_LBU: e.aluop = rv_pipe_pkg::ALU_LBU;
				default: e.aluop = rv_pipe_pkg::ALU_LHU;
			endcase
		end
		rv_isa_pkg::OPC_STORE: begin
			e.alusel = rv_pipe_pkg::SEL_LOAD_STORE;
			rd1 = 1'b1;
			rd2 = 1'b1;
			case (w[14:12])
				rv_isa_pkg::F3_SB: e.aluop = rv_pipe_pkg::ALU_SB;
				rv_isa_pkg::F3_SH: e.aluop = rv_pipe_pkg::ALU_SH;
				default: e.aluop = rv_pipe_pkg::ALU_SW;
			endcase
		end
		rv_isa_pkg::OPC_OP_IMM: begin
			e = alu_expect(e, w[14:12], w[30], 1'b1);
			e.wreg = 1'b1;
			rd1 = 1'b1;
			// slli, srli, srai carry shamt only
			imm = (w[13:12] == 2'b01) ? {27'h0, w[24:20]} : {{20{w[31]}}, w[31:20]};
		end
		rv_isa_pkg::OPC_OP: begin
			e = alu_expect(e, w[14:12], w[30], 1'b0);
			e.wreg = 1'b1;
			rd1 = 1'b1;
			rd2 = 1'b1;
		end
		default: ;
	endcase
	e.rd1 = rd1;
	e.rd2 = rd2;
	e.op1 = pick_operand(rd1, w[19:15], imm, rf1, b);
	e.op2 = pick_operand(rd2, w[24:20], imm, rf2, b);
	if (w[6:0] == rv_isa_pkg::OPC_JAL) begin
		e.flag = 1'b1;
		e.target = pc_v + off;
	end else if (w[6:0] == rv_isa_pkg::OPC_JALR) begin
		e.flag = 1'b1;
		e.target = e.op1 + off;
	end else if (w[6:0] == rv_isa_pkg::OPC_BRANCH) begin
		e.target = pc_v + off;
		case (w[14:12])
			rv_isa_pkg::F3_BEQ: e.flag = (e.op1 == e.op2);
			rv_isa_pkg::F3_BNE: e.flag = (e.op1 != e.op2);
			rv_isa_pkg::F3_BLT: e.flag = ($signed(e.op1) < $signed(e.op2));
			rv_isa_pkg::F3_BGE: e.flag = ($signed(e.op1) >= $signed(e.op2));
			rv_isa_pkg::F3_BLTU: e.flag = (e.op1 < e.op2);
			default: e.flag = (e.op1 >= e.op2);
		endcase
	end
	return e;
endfunction

`endif

/* bench/tb_id_stage.sv */
`include "rv_config.svh"

module tb_id_stage;

	localparam int NUM_TXN = 400;
	localparam int CLK_PERIOD = 4;
	localparam int ACK_LIMIT = 8; // cycles before a handshake counts as hung
	localparam int TXN_CYCLES = 12; // upper bound of one four-phase handshake
	localparam int WATCHDOG = (10 + NUM_TXN * TXN_CYCLES) * CLK_PERIOD * 2;

	logic                  clk;
	logic                  arst_n;
	logic                  inst_req;
	logic                  inst_ack;
	logic [31:0]           inst;
	logic [`RV_XLEN-1:0]   pc;
	logic                  reg_read [`RV_NUM_SRC];
	logic [`RV_REG_AW-1:0] reg_addr [`RV_NUM_SRC];
	logic [`RV_XLEN-1:0]   reg_data [`RV_NUM_SRC];
	logic                  ex_wreg;
	logic [`RV_REG_AW-1:0] ex_wd;
	logic [`RV_XLEN-1:0]   ex_wdata;
	logic                  mem_wreg;
	logic [`RV_REG_AW-1:0] mem_wd;
	logic [`RV_XLEN-1:0]   mem_wdata;
	rv_pipe_pkg::aluop_e   aluop;
	rv_pipe_pkg::alusel_e  alusel;
	logic [`RV_REG_AW-1:0] wd;
	logic                  wreg;
	logic [`RV_XLEN-1:0]   op1;
	logic [`RV_XLEN-1:0]   op2;
	logic                  branch_flag;
	logic [`RV_XLEN-1:0]   branch_target;
	logic [`RV_XLEN-1:0]   link_addr;
	logic [`RV_XLEN-1:0]   rf_key; // new register file contents per transaction
	int                    seed = 87265;

	`include "id_model.svh"

	id_stage dut (
		.clk_i           (clk),
		.arst_n_i        (arst_n),
		.inst_req_i      (inst_req),
		.inst_ack_o      (inst_ack),
		.inst_i          (inst),
		.pc_i            (pc),
		.reg_read_o      (reg_read),
		.reg_addr_o      (reg_addr),
		.reg_data_i      (reg_data),
		.ex_wreg_i       (ex_wreg),
		.ex_wd_i         (ex_wd),
		.ex_wdata_i      (ex_wdata),
		.mem_wreg_i      (mem_wreg),
		.mem_wd_i        (mem_wd),
		.mem_wdata_i     (mem_wdata),
		.aluop_o         (aluop),
		.alusel_o        (alusel),
		.wd_o            (wd),
		.wreg_o          (wreg),
		.op1_o           (op1),
		.op2_o           (op2),
		.branch_flag_o   (branch_flag),
		.branch_target_o (branch_target),
		.link_addr_o     (link_addr)
	);

	function automatic logic [`RV_XLEN-1:0] reg_value(input logic [`RV_XLEN-1:0] key,
		input logic [`RV_REG_AW-1:0] a);
		return key ^ ({{(`RV_XLEN-`RV_REG_AW){1'b0}}, a} * 32'h9e3779b9);
	endfunction

	// combinational register file
	assign reg_data[0] = reg_value(rf_key, reg_addr[0]);
	assign reg_data[1] = reg_value(rf_key, reg_addr[1]);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin : watchdog
		#(WATCHDOG);
		$display("watchdog expired, the transactions did not finish in time");
		$display("Regression failed");
		$fatal(1, "watchdog");
	end

	task automatic expect_equal(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		if (got !== exp) begin
			$display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
			$display("Regression failed");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	task automatic compare_outputs(input expect_t e);
		expect_equal(32'(aluop), 32'(e.aluop), "aluop_o");
		expect_equal(32'(alusel), 32'(e.alusel), "alusel_o");
		expect_equal(32'(wd), 32'(e.wd), "wd_o");
		expect_equal(32'(wreg), 32'(e.wreg), "wreg_o");
		expect_equal(op1, e.op1, "op1_o");
		expect_equal(op2, e.op2, "op2_o");
		expect_equal(32'(branch_flag), 32'(e.flag), "branch_flag_o");
		if (e.flag)
			expect_equal(branch_target, e.target, "branch_target_o");
		expect_equal(link_addr, e.link, "link_addr_o");
	endtask

	// read port follows the instruction while it is held
	task automatic compare_reads(input expect_t e, input logic [31:0] w);
		expect_equal(32'(reg_read[0]), 32'(e.rd1), "reg_read_o[0]");
		expect_equal(32'(reg_read[1]), 32'(e.rd2), "reg_read_o[1]");
		expect_equal(32'(reg_addr[0]), 32'(w[19:15]), "reg_addr_o[0]");
		expect_equal(32'(reg_addr[1]), 32'(w[24:20]), "reg_addr_o[1]");
	endtask

	// counts falling edges until ack reaches level
	task automatic wait_ack(input logic level, output int cycles);
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (inst_ack !== level && cycles < ACK_LIMIT);
		if (inst_ack !== level) begin
			$display("handshake hung, inst_ack_o never reached %0b", level);
			$display("Regression failed");
			$fatal(1, "handshake timeout");
		end
	endtask

	// signed and unsigned corner words
	function automatic logic [31:0] edge_value(input logic [2:0] k, input logic [31:0] r);
		case (k)
			3'd0: return 32'h0000_0000;
			3'd1: return 32'h0000_0001;
			3'd2: return 32'h7fff_ffff;
			3'd3: return 32'h8000_0000;
			3'd4: return 32'hffff_ffff;
			default: return r;
		endcase
	endfunction

	// random encoding of one of the eight kept opcodes
	task automatic gen_inst(output logic [31:0] w);
		logic [31:0] r;
		logic        alt;
		r = $random(seed);
		w = $random(seed);
		case (r[2:0])
			3'd0: w[6:0] = rv_isa_pkg::OPC_LUI;
			3'd1: w[6:0] = rv_isa_pkg::OPC_JAL;
			3'd2: begin
				w[6:0] = rv_isa_pkg::OPC_JALR;
				w[14:12] = 3'b000;
			end
			3'd3: begin
				w[6:0] = rv_isa_pkg::OPC_BRANCH;
				if (w[14:13] == 2'b01)
					w[14] = 1'b1; // 010 and 011 become bltu and bgeu
			end
			3'd4: begin
				w[6:0] = rv_isa_pkg::OPC_LOAD;
				if (w[13:12] == 2'b11 || w[14:13] == 2'b11)
					w[14:12] = rv_isa_pkg::F3_LW;
			end
			3'd5: begin
				w[6:0] = rv_isa_pkg::OPC_STORE;
				w[14] = 1'b0;
				if (w[13:12] == 2'b11)
					w[13:12] = 2'b00;
			end
			3'd6: begin
				w[6:0] = rv_isa_pkg::OPC_OP_IMM;
				if (w[13:12] == 2'b01)
					w[31:25] = (w[30] && w[14]) ? rv_isa_pkg::F7_ALT : rv_isa_pkg::F7_BASE;
			end
			default: begin
				w[6:0] = rv_isa_pkg::OPC_OP;
				alt = w[30] && (w[14:12] == rv_isa_pkg::F3_ADD_SUB ||
					w[14:12] == rv_isa_pkg::F3_SRL_SRA);
				w[31:25] = alt ? rv_isa_pkg::F7_ALT : rv_isa_pkg::F7_BASE;
			end
		endcase
	endtask

	// bypass fields, often colliding with rs1 or rs2
	task automatic gen_bypass(input logic [31:0] w, output byp_t b);
		logic [31:0] r;
		logic [31:0] d0;
		logic [31:0] d1;
		r = $random(seed);
		d0 = $random(seed);
		d1 = $random(seed);
		b.ex_wreg = r[0] | r[1];
		b.mem_wreg = r[2] | r[3];
		b.ex_wd = r[4] ? (r[5] ? w[19:15] : w[24:20]) : r[10:6];
		b.mem_wd = r[11] ? (r[12] ? w[19:15] : w[24:20]) : r[17:13];
		b.ex_wdata = r[18] ? edge_value(r[21:19], d0) : d0;
		b.mem_wdata = r[22] ? edge_value(r[25:23], d1) : d1;
	endtask

	task automatic run_txn();
		logic [31:0]         w;
		logic [31:0]         r;
		logic [`RV_XLEN-1:0] pc_v;
		logic [`RV_XLEN-1:0] key;
		byp_t                b;
		expect_t             e;
		int                  cycles;
		gen_inst(w);
		gen_bypass(w, b);
		pc_v = $random(seed);
		key = $random(seed);
		r = $random(seed);
		e = predict(w, pc_v, b, reg_value(key, w[19:15]), reg_value(key, w[24:20]));
		@(posedge clk);
		inst <= {w[7:0], w[15:8], w[23:16], w[31:24]}; // fetch byte order
		pc <= pc_v;
		rf_key <= key;
		ex_wreg <= b.ex_wreg;
		ex_wd <= b.ex_wd;
		ex_wdata <= b.ex_wdata;
		mem_wreg <= b.mem_wreg;
		mem_wd <= b.mem_wd;
		mem_wdata <= b.mem_wdata;
		inst_req <= 1'b1;
		wait_ack(1'b1, cycles);
		expect_equal(cycles, 2, "ack latency after request");
		compare_outputs(e);
		compare_reads(e, w);
		// stall by keeping req up
		repeat (r[1:0]) begin
			@(negedge clk);
			expect_equal(32'(inst_ack), 32'd1, "inst_ack_o while request held");
			compare_outputs(e);
			compare_reads(e, w);
		end
		@(posedge clk);
		inst_req <= 1'b0;
		inst <= r; // must not reach the outputs
		ex_wdata <= ~b.ex_wdata;
		wait_ack(1'b0, cycles);
		expect_equal(cycles, 2, "ack release latency");
		compare_outputs(e);
	endtask

	initial begin : stimulus
		arst_n = 1'b0;
		inst_req = 1'b0;
		inst = '0;
		pc = '0;
		rf_key = '0;
		ex_wreg = 1'b0;
		ex_wd = '0;
		ex_wdata = '0;
		mem_wreg = 1'b0;
		mem_wd = '0;
		mem_wdata = '0;
		repeat (10) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		expect_equal(32'(inst_ack), 32'd0, "inst_ack_o after reset");
		expect_equal(32'(wreg), 32'd0, "wreg_o after reset");
		expect_equal(32'(branch_flag), 32'd0, "branch_flag_o after reset");
		expect_equal(32'(aluop), 32'(rv_pipe_pkg::ALU_NOP), "aluop_o after reset");
		for (int n = 0; n < NUM_TXN; n++)
			run_txn();
		$display("Regression passed");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+include
hdl/rv_isa_pkg.sv
hdl/rv_pipe_pkg.sv
hdl/id_if.sv
hdl/inst_decoder.sv
hdl/operand_mux.sv
hdl/branch_resolve.sv
hdl/id_stage.sv
bench/tb_id_stage.sv

/* Makefile */
SRCS := $(filter-out +%,$(shell cat verilog.f)) $(wildcard include/*.svh)

.PHONY: run clean

run: obj_dir/Vtb_id_stage
	@out=$$(./obj_dir/Vtb_id_stage); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Regression passed$$"

obj_dir/Vtb_id_stage: verilog.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_id_stage -f verilog.f

clean:
	rm -rf obj_dir
